// File: sim.f
+incdir+tests
verilog/aes_pkg.sv
verilog/aes_key_slv.sv
verilog/aes_key_expand.sv
verilog/aes_round_core.sv
verilog/aes_top.sv
tests/aes_tb.sv

// File: run.sh
#!/bin/sh
set -e
verilator --binary --assert --top-module aes_tb -f sim.f
output=$(./obj_dir/Vaes_tb 2>&1) || true
echo "$output"
if echo "$output" | grep -q 'All tests passed!'; then
  exit 0
else
  exit 1
fi

// File: tests/aes_tb_model.svh
`ifndef AES_TB_MODEL_SVH
`define AES_TB_MODEL_SVH

// Multiply by x in GF(2^8)
function automatic logic [7:0] gf_double(input logic [7:0] b);
  logic [7:0] r;
  r = {b[6:0], 1'b0};
  if (b[7])
    r = r ^ 8'h1b;
  return r;
endfunction

// Byte-wise AES-128 reference, byte 0 is the most significant byte
function automatic logic [127:0] model_encrypt(input logic [127:0] key,
                                               input logic [127:0] pt);
  logic [7:0] w [0:175];
  logic [7:0] s [0:15];
  logic [7:0] t [0:15];
  logic [7:0] rc;
  logic [7:0] all4;
  logic [127:0] ct;
  // Expanded key, 176 bytes
  for (int i = 0; i < 16; i++)
    w[i] = key[127-8*i -: 8];
  rc = 8'h01;
  for (int i = 16; i < 176; i += 4)
  begin
    if (i % 16 == 0)
    begin
      w[i] = w[i-16] ^ aes_sbox(w[i-3]) ^ rc;
      w[i+1] = w[i-15] ^ aes_sbox(w[i-2]);
      w[i+2] = w[i-14] ^ aes_sbox(w[i-1]);
      w[i+3] = w[i-13] ^ aes_sbox(w[i-4]);
      rc = gf_double(rc);
    end
    else
    begin
      for (int j = 0; j < 4; j++)
        w[i+j] = w[i+j-16] ^ w[i+j-4];
    end
  end
  for (int i = 0; i < 16; i++)
    s[i] = pt[127-8*i -: 8] ^ w[i];
  for (int r = 1; r <= 10; r++)
  begin
    // Byte in row j of column c comes from column c+j
    for (int i = 0; i < 16; i++)
      t[i] = aes_sbox(s[(i + 4*(i%4)) % 16]);
    for (int c = 0; c < 4; c++)
    begin
      all4 = t[4*c] ^ t[4*c+1] ^ t[4*c+2] ^ t[4*c+3];
      for (int j = 0; j < 4; j++)
      begin
        if (r == 10)
          s[4*c+j] = t[4*c+j];
        else
          s[4*c+j] = t[4*c+j] ^ all4 ^ gf_double(t[4*c+j] ^ t[4*c+(j+1)%4]);
        s[4*c+j] = s[4*c+j] ^ w[16*r+4*c+j];
      end
    end
  end
  for (int i = 0; i < 16; i++)
    ct[127-8*i -: 8] = s[i];
  return ct;
endfunction

`endif

// File: tests/aes_tb.sv
`timescale 1ns/100ps
`default_nettype none

module aes_tb import aes_pkg::*; ();

  localparam int HANDSHAKE_LIMIT = 50;
  localparam int KEY_POLL_LIMIT = 20;
  localparam int LATENCY = 11;
  localparam block_t KNOWN_CT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic aclk;
  logic aresetn;
  axil_addr_t awaddr;
  logic awvalid;
  logic awready;
  axil_data_t wdata;
  axil_strb_t wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  axil_addr_t araddr;
  logic arvalid;
  logic arready;
  axil_data_t rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  block_t in_data;
  logic in_valid;
  logic in_ready;
  block_t out_data;
  logic out_valid;
  logic out_ready;

  int seed = 27;
  // Expected contents of the two key registers
  axil_data_t key_lo_exp;
  axil_data_t key_hi_exp;

  aes_top i_dut (
    .aclk(aclk),
    .aresetn(aresetn),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wstrb(wstrb),
    .wvalid(wvalid),
    .wready(wready),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rresp(rresp),
    .rvalid(rvalid),
    .rready(rready),
    .in_data(in_data),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  `include "aes_tb_model.svh"

  initial
  begin
    aclk = 1'b0;
    forever
      #5 aclk = ~aclk;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  // Advance to 1 ns after the next rising edge
  task automatic step();
    @(posedge aclk);
    #1;
  endtask

  task automatic stop_on_failure();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic timed_out(input string what);
    $display("Timeout: %s did not arrive in time, at time %0t", what, $time);
    stop_on_failure();
  endtask

  task automatic check_value(input logic [127:0] got, input logic [127:0] expected,
                             input string what);
    if (got !== expected)
    begin
      $display("** Error at time %0t: %s, got %h, expected %h", $time, what, got, expected);
      stop_on_failure();
    end
  endtask

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  function automatic axil_addr_t reg_addr(input logic [1:0] idx);
    return {idx, 3'b000};
  endfunction

  function automatic axil_data_t merge_bytes(input axil_data_t old_val, input axil_data_t new_val,
                                             input axil_strb_t strb);
    axil_data_t res;
    res = old_val;
    for (int b = 0; b < 8; b++)
    begin
      if (strb[b])
        res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  // ------------------------------------------------------------
  // AXI4-Lite master
  // ------------------------------------------------------------
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
    int n;
    awaddr = addr;
    awvalid = 1'b1;
    wdata = data;
    wstrb = strb;
    wvalid = 1'b1;
    n = 0;
    while (!(awready && wready))
    begin
      step();
      n++;
      if (n > HANDSHAKE_LIMIT)
        timed_out("awready and wready");
    end
    step();
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b1;
    n = 0;
    while (!bvalid)
    begin
      step();
      n++;
      if (n > HANDSHAKE_LIMIT)
        timed_out("bvalid");
    end
    check_value(128'(bresp), 128'(0), "bresp");
    step();
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
    int n;
    araddr = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready)
    begin
      step();
      n++;
      if (n > HANDSHAKE_LIMIT)
        timed_out("arready");
    end
    step();
    arvalid = 1'b0;
    rready = 1'b1;
    n = 0;
    while (!rvalid)
    begin
      step();
      n++;
      if (n > HANDSHAKE_LIMIT)
        timed_out("rvalid");
    end
    data = rdata;
    check_value(128'(rresp), 128'(0), "rresp");
    step();
    rready = 1'b0;
  endtask

  // Poll the status register until key_ready shows up
  task automatic wait_key_ready();
    axil_data_t rd;
    int n;
    n = 0;
    axil_read(reg_addr(STATUS_REG), rd);
    while (rd[0] !== 1'b1)
    begin
      n++;
      if (n > KEY_POLL_LIMIT)
        timed_out("key_ready in the status register");
      axil_read(reg_addr(STATUS_REG), rd);
    end
    check_value(128'(rd), 128'(1), "status register after key expansion");
  endtask

  task automatic load_key(input key_t k);
    axil_write(reg_addr(KEY_LOW_REG), k[63:0], 8'hff);
    axil_write(reg_addr(KEY_HIGH_REG), k[127:64], 8'hff);
    wait_key_ready();
  endtask

  // ------------------------------------------------------------
  // Block streams
  // ------------------------------------------------------------
  task automatic encrypt_block(input block_t pt, input key_t k, input int hold);
    block_t expected;
    int n;
    expected = model_encrypt(k, pt);
    in_data = pt;
    in_valid = 1'b1;
    n = 0;
    while (!in_ready)
    begin
      step();
      n++;
      if (n > HANDSHAKE_LIMIT)
        timed_out("in_ready");
    end
    step();
    in_valid = 1'b0;
    // Count edges from the accepting edge
    n = 0;
    while (!out_valid)
    begin
      step();
      n++;
      if (n > HANDSHAKE_LIMIT)
        timed_out("out_valid");
    end
    check_value(128'(n), 128'(LATENCY), "cycles from accept to out_valid");
    check_value(out_data, expected, "ciphertext");
    for (int i = 0; i < hold; i++)
    begin
      step();
      check_value(128'(out_valid), 128'(1), "out_valid under back-pressure");
      check_value(out_data, expected, "out_data under back-pressure");
      check_value(128'(in_ready), 128'(0), "in_ready under back-pressure");
    end
    out_ready = 1'b1;
    step();
    out_ready = 1'b0;
    check_value(128'(out_valid), 128'(0), "out_valid after transfer");
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial
  begin
    axil_data_t rd;
    axil_data_t wd;
    axil_strb_t ws;
    logic [31:0] r;
    logic [1:0] idx;
    key_t k;
    block_t pt;
    int nblk;
    aresetn = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    in_data = '0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    key_lo_exp = '0;
    key_hi_exp = '0;
    repeat (4) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    // State after reset
    check_value(128'({awready, wready, bvalid, arready, rvalid, in_ready, out_valid}),
                128'(0), "handshake outputs after reset");
    axil_read(reg_addr(STATUS_REG), rd);
    check_value(128'(rd), 128'(0), "status after reset");
    axil_read(reg_addr(KEY_LOW_REG), rd);
    check_value(128'(rd), 128'(0), "key low after reset");
    axil_read(reg_addr(KEY_HIGH_REG), rd);
    check_value(128'(rd), 128'(0), "key high after reset");
    check_value(128'(in_ready), 128'(0), "in_ready without a key");

    // Byte-strobed key register writes, random byte offsets
    for (int i = 0; i < 24; i++)
    begin
      r = next_random();
      idx = r[0] ? KEY_HIGH_REG : KEY_LOW_REG;
      ws = r[15:8];
      wd = {next_random(), next_random()};
      axil_write({idx, r[6:4]}, wd, ws);
      if (idx == KEY_HIGH_REG)
        key_hi_exp = merge_bytes(key_hi_exp, wd, ws);
      else
        key_lo_exp = merge_bytes(key_lo_exp, wd, ws);
      axil_read({KEY_LOW_REG, r[22:20]}, rd);
      check_value(128'(rd), 128'(key_lo_exp), "key low readback");
      axil_read({KEY_HIGH_REG, r[26:24]}, rd);
      check_value(128'(rd), 128'(key_hi_exp), "key high readback");
    end

    // Status and unmapped index ignore writes
    axil_write(reg_addr(STATUS_REG), {next_random(), next_random()}, 8'hff);
    axil_write(reg_addr(2'd3), {next_random(), next_random()}, 8'hff);
    axil_read(reg_addr(2'd3), rd);
    check_value(128'(rd), 128'(0), "unmapped register");
    axil_read(reg_addr(KEY_LOW_REG), rd);
    check_value(128'(rd), 128'(key_lo_exp), "key low after other writes");
    axil_read(reg_addr(KEY_HIGH_REG), rd);
    check_value(128'(rd), 128'(key_hi_exp), "key high after other writes");

    // Known vector from the standard
    k = 128'h000102030405060708090a0b0c0d0e0f;
    pt = 128'h00112233445566778899aabbccddeeff;
    check_value(model_encrypt(k, pt), KNOWN_CT, "model on the known vector");
    axil_write(reg_addr(KEY_LOW_REG), k[63:0], 8'hff);
    axil_write(reg_addr(KEY_HIGH_REG), k[127:64], 8'hff);
    axil_read(reg_addr(STATUS_REG), rd);
    check_value(128'(rd), 128'(0), "status during key expansion");
    wait_key_ready();
    encrypt_block(pt, k, 0);

    // Random keys and blocks
    for (int i = 0; i < 20; i++)
    begin
      k = {next_random(), next_random(), next_random(), next_random()};
      load_key(k);
      r = next_random();
      nblk = 1 + int'(r[1:0]);
      for (int j = 0; j < nblk; j++)
      begin
        pt = {next_random(), next_random(), next_random(), next_random()};
        encrypt_block(pt, k, 0);
      end
    end

    // Back-pressure on the output stream
    for (int i = 0; i < 8; i++)
    begin
      r = next_random();
      pt = {next_random(), next_random(), next_random(), next_random()};
      encrypt_block(pt, k, 1 + int'(r[4:2]));
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/aes_top.sv
`timescale 1ns/100ps
`default_nettype none

module aes_top import aes_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,

  // AXI4-Lite control
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  axil_strb_t wstrb,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output axil_data_t rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,

  // Block streams
  input  block_t     in_data,
  input  logic       in_valid,
  output logic       in_ready,
  output block_t     out_data,
  output logic       out_valid,
  input  logic       out_ready
);

  key_t key;
  logic key_start;
  logic key_ready;
  key_t round_key;
  round_t round_sel;

  aes_key_slv i_key_slv (
    .aclk(aclk),
    .aresetn(aresetn),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wstrb(wstrb),
    .wvalid(wvalid),
    .wready(wready),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rresp(rresp),
    .rvalid(rvalid),
    .rready(rready),
    .key_ready(key_ready),
    .key(key),
    .key_start(key_start)
  );

  aes_key_expand i_key_expand (
    .aclk(aclk),
    .aresetn(aresetn),
    .key_start(key_start),
    .key(key),
    .round_sel(round_sel),
    .round_key(round_key),
    .key_ready(key_ready)
  );

  aes_round_core i_round_core (
    .aclk(aclk),
    .aresetn(aresetn),
    .in_data(in_data),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .key_ready(key_ready),
    .round_key(round_key),
    .round_sel(round_sel)
  );

endmodule

`default_nettype wire

// File: verilog/aes_round_core.sv
`timescale 1ns/100ps
`default_nettype none

module aes_round_core import aes_pkg::*; (
  input  logic   aclk,
  input  logic   aresetn,
  input  block_t in_data,
  input  logic   in_valid,
  output logic   in_ready,
  output block_t out_data,
  output logic   out_valid,
  input  logic   out_ready,
  input  logic   key_ready,
  input  key_t   round_key,
  output round_t round_sel
);

  core_state_t st;
  round_t rnd;
  block_t blk;
  block_t shifted;
  block_t mixed;
  block_t round_out;

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // ------------------------------------------------------------
  // Round datapath
  // ------------------------------------------------------------
  // SubBytes and ShiftRows, row r rotates left by r columns
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shifted[127-8*(4*c+r) -: 8] = aes_sbox(blk[127-8*(4*((c+r)%4)+r) -: 8]);
      end
    end
  end

  always_comb
  begin
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    for (int c = 0; c < 4; c++)
    begin
      a0 = shifted[127-32*c -: 8];
      a1 = shifted[119-32*c -: 8];
      a2 = shifted[111-32*c -: 8];
      a3 = shifted[103-32*c -: 8];
      mixed[127-32*c -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
      mixed[119-32*c -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
      mixed[111-32*c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
      mixed[103-32*c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    end
  end

  // Last round has no MixColumns
  assign round_out = ((rnd == N_ROUNDS) ? shifted : mixed) ^ round_key;

  assign round_sel = rnd;
  assign in_ready = (st == idle) && key_ready;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      st <= idle;
      rnd <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      case (st)
        idle:
          if (in_valid && in_ready)
          begin
            rnd <= 4'd1;
            st <= run;
          end
        run:
          if (rnd == N_ROUNDS)
          begin
            rnd <= '0;
            st <= done;
          end
          else
            rnd <= rnd + 4'd1;
        done:
          // First cycle loads the output register
          if (!out_valid)
            out_valid <= 1'b1;
          else if (out_ready)
          begin
            out_valid <= 1'b0;
            st <= idle;
          end
        default: st <= idle;
      endcase
    end
  end

  // State and output registers
  always_ff @(posedge aclk)
  begin
    if (st == idle && in_valid && in_ready)
      blk <= in_data ^ round_key;
    else if (st == run)
      blk <= round_out;
    if (st == done && !out_valid)
      out_data <= blk;
  end

  out_stable_a: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: verilog/aes_key_expand.sv
`timescale 1ns/100ps
`default_nettype none

module aes_key_expand import aes_pkg::*; (
  input  logic   aclk,
  input  logic   aresetn,
  input  logic   key_start,
  input  key_t   key,
  input  round_t round_sel,
  output key_t   round_key,
  output logic   key_ready
);

  key_t rk_table [0:N_ROUNDS];
  key_t last_key;
  key_t next_key;
  round_t cnt;
  logic busy;

  // One step of the AES-128 key schedule
  function automatic key_t derive_key(input key_t prev, input round_t rnd);
    logic [31:0] t;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    // RotWord then SubWord on the last word
    t = {aes_sbox(prev[23:16]), aes_sbox(prev[15:8]),
         aes_sbox(prev[7:0]), aes_sbox(prev[31:24])};
    t = t ^ {aes_rcon(rnd), 24'h000000};
    w0 = prev[127:96] ^ t;
    w1 = prev[95:64] ^ w0;
    w2 = prev[63:32] ^ w1;
    w3 = prev[31:0] ^ w2;
    return {w0, w1, w2, w3};
  endfunction

  assign next_key = derive_key(last_key, cnt);

  // Counter walks rounds 1..10 after the key is loaded
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      cnt <= '0;
      busy <= 1'b0;
      key_ready <= 1'b0;
    end
    else if (key_start)
    begin
      cnt <= 4'd1;
      busy <= 1'b1;
      key_ready <= 1'b0;
    end
    else if (busy)
    begin
      if (cnt == N_ROUNDS)
      begin
        busy <= 1'b0;
        key_ready <= 1'b1;
        cnt <= '0;
      end
      else
        cnt <= cnt + 4'd1;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (key_start)
    begin
      rk_table[0] <= key;
      last_key <= key;
    end
    else if (busy)
    begin
      rk_table[cnt] <= next_key;
      last_key <= next_key;
    end
  end

  assign round_key = rk_table[round_sel];

  round_sel_range_a: assert property (@(posedge aclk) disable iff (!aresetn)
    round_sel <= N_ROUNDS);

endmodule

`default_nettype wire

// File: verilog/aes_key_slv.sv
`timescale 1ns/100ps
`default_nettype none

module aes_key_slv import aes_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,

  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  axil_strb_t wstrb,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output axil_data_t rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,

  input  logic       key_ready,
  output key_t       key,
  output logic       key_start
);

  // ------------------------------------------------------------
  // Declarations
  // ------------------------------------------------------------
  logic [AXIL_ADDR_BITS-ADDR_LSB-1:0] aw_idx;
  logic [AXIL_ADDR_BITS-ADDR_LSB-1:0] ar_idx;
  logic aw_en;
  logic wr_en;
  logic rd_en;

  axil_data_t key_lo;
  axil_data_t key_hi;

  // No error responses, both channels always OKAY
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  assign key = {key_hi, key_lo};

  // ------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------
  assign wr_en = awready && awvalid && wready && wvalid;

  // Address and data are taken together, one write outstanding at most
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      awready <= 1'b0;
      wready <= 1'b0;
      aw_en <= 1'b1;
      aw_idx <= '0;
    end
    else
    begin
      if (!awready && awvalid && wvalid && aw_en)
      begin
        awready <= 1'b1;
        wready <= 1'b1;
        aw_en <= 1'b0;
        aw_idx <= awaddr[AXIL_ADDR_BITS-1:ADDR_LSB];
      end
      else
      begin
        awready <= 1'b0;
        wready <= 1'b0;
        if (bvalid && bready)
          aw_en <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      bvalid <= 1'b0;
    else if (wr_en && !bvalid)
      bvalid <= 1'b1;
    else if (bvalid && bready)
      bvalid <= 1'b0;
  end

  // Key registers with byte strobes
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      key_lo <= '0;
      key_hi <= '0;
      key_start <= 1'b0;
    end
    else
    begin
      key_start <= 1'b0;
      if (wr_en)
      begin
        case (aw_idx)
          KEY_LOW_REG:
            for (int i = 0; i < AXIL_DATA_BITS/8; i++)
            begin
              if (wstrb[i])
                key_lo[i*8 +: 8] <= wdata[i*8 +: 8];
            end
          KEY_HIGH_REG:
          begin
            for (int i = 0; i < AXIL_DATA_BITS/8; i++)
            begin
              if (wstrb[i])
                key_hi[i*8 +: 8] <= wdata[i*8 +: 8];
            end
            // Writing the high half kicks off the key schedule
            key_start <= |wstrb;
          end
          default: ;
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------
  assign rd_en = arready && arvalid && !rvalid;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      arready <= 1'b0;
      ar_idx <= '0;
    end
    else if (!arready && arvalid && !rvalid)
    begin
      arready <= 1'b1;
      ar_idx <= araddr[AXIL_ADDR_BITS-1:ADDR_LSB];
    end
    else
      arready <= 1'b0;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      rvalid <= 1'b0;
    else if (rd_en)
      rvalid <= 1'b1;
    else if (rvalid && rready)
      rvalid <= 1'b0;
  end

  // Read data mux, status in bit 0 of register 0
  always_ff @(posedge aclk)
  begin
    if (rd_en)
    begin
      case (ar_idx)
        STATUS_REG: rdata <= {{(AXIL_DATA_BITS-1){1'b0}}, key_ready};
        KEY_LOW_REG: rdata <= key_lo;
        KEY_HIGH_REG: rdata <= key_hi;
        default: rdata <= '0;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  bvalid_hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid);

  key_start_pulse_a: assert property (@(posedge aclk) disable iff (!aresetn)
    key_start |=> !key_start);

endmodule

`default_nettype wire

// File: verilog/aes_pkg.sv
`default_nettype none

package aes_pkg;

  // ------------------------------------------------------------
  // Widths and register map
  // ------------------------------------------------------------
  localparam int AXIL_DATA_BITS = 64;
  localparam int AXIL_ADDR_BITS = 5;
  // Register index sits above the byte offset
  localparam int ADDR_LSB = 3;

  localparam logic [AXIL_ADDR_BITS-ADDR_LSB-1:0] STATUS_REG = 2'd0;
  localparam logic [AXIL_ADDR_BITS-ADDR_LSB-1:0] KEY_LOW_REG = 2'd1;
  localparam logic [AXIL_ADDR_BITS-ADDR_LSB-1:0] KEY_HIGH_REG = 2'd2;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  typedef logic [AXIL_DATA_BITS-1:0] axil_data_t;
  typedef logic [AXIL_ADDR_BITS-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_BITS/8-1:0] axil_strb_t;

  // Byte 0 of a block or key is the most significant byte
  typedef logic [127:0] block_t;
  typedef logic [127:0] key_t;
  typedef logic [3:0] round_t;

  typedef enum logic [1:0] {
    idle,
    run,
    done
  } core_state_t;

  localparam round_t N_ROUNDS = 4'd10;

  // ------------------------------------------------------------
  // S-box, one row of sixteen entries per line
  // ------------------------------------------------------------
  localparam logic [0:255][7:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic logic [7:0] aes_sbox(input logic [7:0] b);
    return SBOX[b];
  endfunction

  // Round constant for the key schedule, rounds 1 to 10
  function automatic logic [7:0] aes_rcon(input round_t rnd);
    logic [7:0] rc;
    case (rnd)
      4'd1: rc = 8'h01;
      4'd2: rc = 8'h02;
      4'd3: rc = 8'h04;
      4'd4: rc = 8'h08;
      4'd5: rc = 8'h10;
      4'd6: rc = 8'h20;
      4'd7: rc = 8'h40;
      4'd8: rc = 8'h80;
      4'd9: rc = 8'h1b;
      4'd10: rc = 8'h36;
      default: rc = 8'h00;
    endcase
    return rc;
  endfunction

endpackage

`default_nettype wire
